// File: Makefile
VERILATOR ?= verilator
TOP ?= datapathTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail when the log reports failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TB FAILED" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ] || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/alu.sv
// Combinational 16-bit ALU with carry, zero, negative and overflow flags
`timescale 1ns/1ns
`default_nettype none

module alu (
	input wire isaPkg::aluOpT op_i,
	input wire logic [isaPkg::wordW-1:0] a_i,
	input wire logic [isaPkg::wordW-1:0] b_i,
	input wire logic cin_i,
	output logic [isaPkg::wordW-1:0] res_o,
	output logic [isaPkg::flagW-1:0] flags_o
);

	logic [isaPkg::wordW-1:0] addB;
	logic addCin;
	logic [isaPkg::wordW:0] sum;
	logic addOvf;
	logic carry;
	logic ovf;

	// Subtraction runs through the same adder as a + ~b + carry-in
	always_comb begin
		addB = b_i;
		addCin = 1'b0;
		case (op_i)
			isaPkg::OP_ADDC: addCin = cin_i;
			isaPkg::OP_SUB: begin
				addB = ~b_i;
				addCin = 1'b1;
			end
			isaPkg::OP_SUBC: begin
				addB = ~b_i;
				addCin = cin_i;
			end
			default: ;
		endcase
	end

	assign sum = {1'b0, a_i} + {1'b0, addB} + {{isaPkg::wordW{1'b0}}, addCin};
	// Operands of equal sign giving a result of the other sign
	assign addOvf = (a_i[isaPkg::wordW-1] == addB[isaPkg::wordW-1]) &&
		(sum[isaPkg::wordW-1] != a_i[isaPkg::wordW-1]);

	always_comb begin
		carry = 1'b0;
		ovf = 1'b0;
		case (op_i)
			isaPkg::OP_ADD, isaPkg::OP_ADDC, isaPkg::OP_SUB, isaPkg::OP_SUBC: begin
				res_o = sum[isaPkg::wordW-1:0];
				carry = sum[isaPkg::wordW];
				ovf = addOvf;
			end
			isaPkg::OP_AND: res_o = a_i & b_i;
			isaPkg::OP_OR: res_o = a_i | b_i;
			isaPkg::OP_XOR: res_o = a_i ^ b_i;
			isaPkg::OP_BIC: res_o = a_i & ~b_i;
			isaPkg::OP_MOV: res_o = b_i;
			isaPkg::OP_SWPB: res_o = {a_i[7:0], a_i[15:8]};
			isaPkg::OP_SRA: begin
				res_o = {a_i[15], a_i[15:1]};
				carry = a_i[0];
			end
			isaPkg::OP_RRC: begin
				res_o = {cin_i, a_i[15:1]};
				carry = a_i[0];
			end
			isaPkg::OP_SXT: res_o = {{8{a_i[7]}}, a_i[7:0]};
			default: res_o = '0;
		endcase
	end

	always_comb begin
		flags_o = '0;
		flags_o[isaPkg::flagC] = carry;
		flags_o[isaPkg::flagZ] = (res_o == '0);
		flags_o[isaPkg::flagN] = res_o[isaPkg::wordW-1];
		flags_o[isaPkg::flagV] = ovf;
	end

endmodule

`default_nettype wire

// File: logic/datapath.sv
// Datapath top: selects, constant table, PC adder, alignment decoder, MAR, OMDR and IR
`timescale 1ns/1ns
`default_nettype none

module datapath (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic pcWr_i,
	input wire logic regWr_i,
	input wire logic memEn_i,
	input wire logic irWr_i,
	input wire logic statWr_i,
	input wire logic flagsWr_i,
	input wire logic byteOp_i,
	input wire logic pcSel_i,
	input wire dpCtlPkg::aluBSelT aluBSel_i,
	input wire dpCtlPkg::adrSelT adrSel_i,
	input wire dpCtlPkg::statWrModeT statWrMode_i,
	input wire dpCtlPkg::regWrModeT regWrMode_i,
	input wire dpCtlPkg::regWrSelT regWrSel_i,
	input wire logic [isaPkg::regAdrW-1:0] regWrAdr_i,
	input wire logic [isaPkg::regAdrW-1:0] regAdrA_i,
	input wire logic [isaPkg::regAdrW-1:0] regAdrB_i,
	input wire isaPkg::aluOpT aluOp_i,
	input wire logic [isaPkg::flagW-1:0] flagsEn_i,
	input wire logic [isaPkg::wordW-1:0] mem_i,
	input wire logic [isaPkg::wordW-1:0] branchOffs_i,
	input wire logic [isaPkg::wordW-1:0] immVal_i,
	input wire logic [isaPkg::wordW-1:0] memOffs_i,
	output logic badMem_o,
	output logic pswAddr_o,
	output logic [1:0] datSel_o,
	output logic [isaPkg::marW-1:0] mar_o,
	output logic [isaPkg::wordW-1:0] omdr_o,
	output logic [isaPkg::wordW-1:0] ir_o,
	output logic [isaPkg::wordW-1:0] status_o
);

	regFileIf rf ();
	statusIf st ();

	logic [isaPkg::wordW-1:0] aluB;
	logic [isaPkg::wordW-1:0] aluRes;
	logic [isaPkg::wordW-1:0] constVal;
	logic [isaPkg::wordW-1:0] addrSrc;

	registerFile u_regFile (.clk_i(clk_i), .rst_i(rst_i), .regs(rf.regs));

	alu u_alu (
		.op_i   (aluOp_i),
		.a_i    (rf.rdDataA),
		.b_i    (aluB),
		.cin_i  (st.flags[isaPkg::flagC]),
		.res_o  (aluRes),
		.flags_o(st.aluFlags)
	);

	statusRegister u_status (.clk_i(clk_i), .rst_i(rst_i), .stat(st.regs));

	assign rf.rdAddrA = regAdrA_i;
	assign rf.rdAddrB = regAdrB_i;
	assign rf.wrEn = regWr_i;
	assign rf.wrMode = regWrMode_i;
	assign rf.wrAddr = regWrAdr_i;
	assign rf.pcWr = pcWr_i;
	// Sequential step of one word, or a branch relative to the current PC
	assign rf.pcNew = rf.pc + (pcSel_i ? branchOffs_i : 16'd2);

	assign st.wrEn = statWr_i;
	assign st.flagsWr = flagsWr_i;
	assign st.wrMode = statWrMode_i;
	assign st.flagsEn = flagsEn_i;
	assign st.wrData = omdr_o;
	assign status_o = st.status;

	assign constVal = isaPkg::constTable[regAdrB_i];

	always_comb begin
		case (aluBSel_i)
			dpCtlPkg::BSEL_REGB: aluB = rf.rdDataB;
			dpCtlPkg::BSEL_CONST: aluB = constVal;
			dpCtlPkg::BSEL_MEMOFFS: aluB = memOffs_i;
			default: aluB = '0;
		endcase

		case (regWrSel_i)
			dpCtlPkg::WR_ALU: rf.wrData = aluRes;
			dpCtlPkg::WR_PC: rf.wrData = rf.pc;
			dpCtlPkg::WR_MEM: rf.wrData = mem_i;
			dpCtlPkg::WR_IMM: rf.wrData = immVal_i;
			default: rf.wrData = '0;
		endcase

		case (adrSel_i)
			dpCtlPkg::ADR_PC: addrSrc = rf.pc;
			dpCtlPkg::ADR_BASE: addrSrc = rf.rdDataA;
			dpCtlPkg::ADR_OFFSET: addrSrc = aluRes;
			default: addrSrc = '0;
		endcase
	end

	// Alignment decoder works on the unregistered address
	assign badMem_o = !byteOp_i && addrSrc[0];
	assign datSel_o = !byteOp_i ? 2'd0 : (addrSrc[0] ? 2'd2 : 2'd1);
	assign pswAddr_o = (addrSrc[isaPkg::wordW-1:1] == isaPkg::pswAddr[isaPkg::wordW-1:1]);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mar_o <= '0;
			omdr_o <= '0;
			ir_o <= '0;
		end else begin
			if (memEn_i) begin
				mar_o <= addrSrc[isaPkg::wordW-1:1];
				// Byte stores replicate the low byte so either lane carries it
				if (byteOp_i) begin
					omdr_o <= {2{rf.rdDataB[isaPkg::byteW-1:0]}};
				end else begin
					omdr_o <= rf.rdDataB;
				end
			end
			if (irWr_i) begin
				ir_o <= mem_i;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/datapathIfs.sv
// Register file interface and status register interface
`timescale 1ns/1ns
`default_nettype none

interface regFileIf;
	logic [isaPkg::regAdrW-1:0] rdAddrA;
	logic [isaPkg::regAdrW-1:0] rdAddrB;
	logic wrEn;
	dpCtlPkg::regWrModeT wrMode;
	logic [isaPkg::regAdrW-1:0] wrAddr;
	logic [isaPkg::wordW-1:0] wrData;
	logic pcWr;
	logic [isaPkg::wordW-1:0] pcNew;
	logic [isaPkg::wordW-1:0] rdDataA;
	logic [isaPkg::wordW-1:0] rdDataB;
	logic [isaPkg::wordW-1:0] pc;

	modport ctl (output rdAddrA, rdAddrB, wrEn, wrMode, wrAddr, wrData, pcWr, pcNew,
		input rdDataA, rdDataB, pc);
	modport regs (input rdAddrA, rdAddrB, wrEn, wrMode, wrAddr, wrData, pcWr, pcNew,
		output rdDataA, rdDataB, pc);
endinterface

interface statusIf;
	logic wrEn;
	logic flagsWr;
	dpCtlPkg::statWrModeT wrMode;
	logic [isaPkg::flagW-1:0] flagsEn;
	logic [isaPkg::flagW-1:0] aluFlags;
	logic [isaPkg::wordW-1:0] wrData;
	logic [isaPkg::flagW-1:0] flags;
	logic [isaPkg::wordW-1:0] status;

	modport ctl (output wrEn, flagsWr, wrMode, flagsEn, aluFlags, wrData,
		input flags, status);
	modport regs (input wrEn, flagsWr, wrMode, flagsEn, aluFlags, wrData,
		output flags, status);
endinterface

`default_nettype wire

// File: logic/dpCtlPkg.sv
// Datapath control encodings: address source, ALU B source, register write source and modes
`default_nettype none

package dpCtlPkg;

	typedef enum logic [1:0] {
		ADR_PC, ADR_BASE, ADR_OFFSET
	} adrSelT;

	typedef enum logic [1:0] {
		BSEL_REGB, BSEL_CONST, BSEL_MEMOFFS
	} aluBSelT;

	typedef enum logic [2:0] {
		WR_ALU, WR_PC, WR_MEM, WR_IMM
	} regWrSelT;

	// HIGHB takes its byte from the low byte of the write data
	typedef enum logic [1:0] {
		WM_WORD, WM_LOWB, WM_HIGHB, WM_LOWZ
	} regWrModeT;

	typedef enum logic [1:0] {
		ST_KEEP, ST_LOAD, ST_SETBITS, ST_CLRBITS
	} statWrModeT;

endpackage

`default_nettype wire

// File: logic/isaPkg.sv
// Machine-level definitions: word and address widths, ALU operations, flag bits, constants
`default_nettype none

package isaPkg;

	localparam int wordW = 16;
	localparam int byteW = 8;
	// Word address, the byte address without bit 0
	localparam int marW = 15;
	localparam int regCount = 8;
	localparam int regAdrW = 3;
	localparam int flagW = 4;

	typedef enum logic [3:0] {
		OP_ADD, OP_ADDC, OP_SUB, OP_SUBC,
		OP_AND, OP_OR, OP_XOR, OP_BIC,
		OP_MOV, OP_SWPB, OP_SRA, OP_RRC, OP_SXT
	} aluOpT;

	// Flag bit positions, shared by ALU output and status word
	localparam int flagC = 0;
	localparam int flagZ = 1;
	localparam int flagN = 2;
	localparam int flagV = 3;

	// Entry i is selected by B register address i
	localparam logic [regCount-1:0][wordW-1:0] constTable = {
		16'hFFFF, 16'd32, 16'd16, 16'd8, 16'd4, 16'd2, 16'd1, 16'd0
	};

	localparam logic [wordW-1:0] pswAddr = 16'hFFFE;

endpackage

`default_nettype wire

// File: logic/registerFile.sv
// Eight general registers with byte-wise write modes, plus the program counter
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input wire logic clk_i,
	input wire logic rst_i,
	regFileIf.regs regs
);

	logic [isaPkg::wordW-1:0] regArr [isaPkg::regCount];
	logic [isaPkg::wordW-1:0] pcQ;
	logic [isaPkg::wordW-1:0] oldVal;
	logic [isaPkg::wordW-1:0] wrValue;

	assign oldVal = regArr[regs.wrAddr];

	// Merge incoming data with the old contents per write mode
	always_comb begin
		case (regs.wrMode)
			dpCtlPkg::WM_WORD:
				wrValue = regs.wrData;
			dpCtlPkg::WM_LOWB:
				wrValue = {oldVal[isaPkg::wordW-1:isaPkg::byteW],
					regs.wrData[isaPkg::byteW-1:0]};
			dpCtlPkg::WM_HIGHB:
				wrValue = {regs.wrData[isaPkg::byteW-1:0], oldVal[isaPkg::byteW-1:0]};
			dpCtlPkg::WM_LOWZ:
				wrValue = {{(isaPkg::wordW - isaPkg::byteW){1'b0}},
					regs.wrData[isaPkg::byteW-1:0]};
			default:
				wrValue = regs.wrData;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < isaPkg::regCount; i++) begin
				regArr[i] <= '0;
			end
			pcQ <= '0;
		end else begin
			if (regs.wrEn) begin
				regArr[regs.wrAddr] <= wrValue;
			end
			if (regs.pcWr) begin
				pcQ <= regs.pcNew;
			end
		end
	end

	// Read ports see a write only from the next cycle on
	assign regs.rdDataA = regArr[regs.rdAddrA];
	assign regs.rdDataB = regArr[regs.rdAddrB];
	assign regs.pc = pcQ;

endmodule

`default_nettype wire

// File: logic/statusRegister.sv
// Status word register with whole-word write modes and masked flag updates
`timescale 1ns/1ns
`default_nettype none

module statusRegister (
	input wire logic clk_i,
	input wire logic rst_i,
	statusIf.regs stat
);

	logic [isaPkg::wordW-1:0] statusQ;
	logic [isaPkg::flagW-1:0] flagsNext;

	// Take the ALU flag only where the enable bit is set
	assign flagsNext = (statusQ[isaPkg::flagW-1:0] & ~stat.flagsEn) |
		(stat.aluFlags & stat.flagsEn);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			statusQ <= '0;
		end else if (stat.wrEn) begin
			// A word write blocks any flag update in the same cycle
			case (stat.wrMode)
				dpCtlPkg::ST_LOAD: statusQ <= stat.wrData;
				dpCtlPkg::ST_SETBITS: statusQ <= statusQ | stat.wrData;
				dpCtlPkg::ST_CLRBITS: statusQ <= statusQ & ~stat.wrData;
				default: statusQ <= statusQ;
			endcase
		end else if (stat.flagsWr) begin
			statusQ[isaPkg::flagW-1:0] <= flagsNext;
		end
	end

	assign stat.flags = statusQ[isaPkg::flagW-1:0];
	assign stat.status = statusQ;

endmodule

`default_nettype wire

// File: project.f
logic/isaPkg.sv
logic/dpCtlPkg.sv
logic/datapathIfs.sv
logic/registerFile.sv
logic/alu.sv
logic/statusRegister.sv
logic/datapath.sv
tests/datapath_props.sv
tests/datapathTb.sv

// File: tests/datapathTb.sv
// Testbench for the datapath: clock, reset, reference model, directed and random tests
`timescale 1ns/1ns
`default_nettype none

module datapathTb;

	// Tests take roughly 400 cycles
	localparam int timeoutCycles = 2000;
	localparam logic [15:0] pswRef = 16'hFFFE;

	logic clk_i = 1'b0;
	logic rst_i, pcWr_i, regWr_i, memEn_i, irWr_i, statWr_i, flagsWr_i, byteOp_i, pcSel_i;
	dpCtlPkg::aluBSelT aluBSel_i;
	dpCtlPkg::adrSelT adrSel_i;
	dpCtlPkg::statWrModeT statWrMode_i;
	dpCtlPkg::regWrModeT regWrMode_i;
	dpCtlPkg::regWrSelT regWrSel_i;
	logic [2:0] regWrAdr_i, regAdrA_i, regAdrB_i;
	isaPkg::aluOpT aluOp_i;
	logic [3:0] flagsEn_i;
	logic [15:0] mem_i, branchOffs_i, immVal_i, memOffs_i;
	logic badMem_o, pswAddr_o;
	logic [1:0] datSel_o;
	logic [14:0] mar_o;
	logic [15:0] omdr_o, ir_o, status_o;

	int seed = 32'hb4f9_36b7;
	int errCount = 0;
	int testStartErrs = 0;
	int passCount = 0;
	int failCount = 0;
	int cycleCount = 0;
	string testName;

	// Reference state
	logic [15:0] refReg [8];
	logic [15:0] refPc, refStatus, refIr;
	logic [15:0] constRef [8] = '{16'h0000, 16'h0001, 16'h0002, 16'h0004,
		16'h0008, 16'h0010, 16'h0020, 16'hFFFF};
	logic [15:0] alignVals [4] = '{16'h1234, 16'h1235, 16'hFFFE, 16'hFFFF};
	logic [15:0] opA, opB;
	logic [19:0] aluOut;
	logic [3:0] en;
	logic odd;
	isaPkg::aluOpT op;

	datapath u_dut (.*);

	always #5 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout: tests did not finish within %0d cycles", timeoutCycles);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [15:0] randWord();
		int r;
		r = $random(seed);
		return r[15:0];
	endfunction

	function automatic logic [15:0] modeRef(input logic [15:0] old, input logic [15:0] d,
		input dpCtlPkg::regWrModeT m);
		case (m)
			dpCtlPkg::WM_LOWB: return {old[15:8], d[7:0]};
			dpCtlPkg::WM_HIGHB: return {d[7:0], old[7:0]};
			dpCtlPkg::WM_LOWZ: return {8'h00, d[7:0]};
			default: return d;
		endcase
	endfunction

	// Returns {V, N, Z, C, result}, arithmetic done on signed and unsigned integers
	function automatic logic [19:0] aluRef(input isaPkg::aluOpT o, input logic [15:0] a,
		input logic [15:0] b, input logic cin);
		int ua, ub, sa, sb, ures, sres, ci;
		logic [15:0] res;
		logic c, v;
		ua = int'(a);
		ub = int'(b);
		sa = int'($signed(a));
		sb = int'($signed(b));
		ci = (o == isaPkg::OP_ADDC || o == isaPkg::OP_SUBC) ? int'(cin) : 0;
		c = 1'b0;
		v = 1'b0;
		case (o)
			isaPkg::OP_ADD, isaPkg::OP_ADDC: begin
				ures = ua + ub + ci;
				sres = sa + sb + ci;
				c = (ures > 65535);
				v = (sres > 32767 || sres < -32768);
				res = ures[15:0];
			end
			isaPkg::OP_SUB, isaPkg::OP_SUBC: begin
				// SUB has no borrow in, SUBC borrows when carry is clear
				ci = (o == isaPkg::OP_SUB) ? 0 : 1 - ci;
				ures = ua - ub - ci;
				sres = sa - sb - ci;
				c = (ures >= 0);
				v = (sres > 32767 || sres < -32768);
				res = ures[15:0];
			end
			isaPkg::OP_AND: res = a & b;
			isaPkg::OP_OR: res = a | b;
			isaPkg::OP_XOR: res = a ^ b;
			isaPkg::OP_BIC: res = a & ~b;
			isaPkg::OP_MOV: res = b;
			isaPkg::OP_SWPB: res = {a[7:0], a[15:8]};
			isaPkg::OP_SRA: begin
				res = {a[15], a[15:1]};
				c = a[0];
			end
			isaPkg::OP_RRC: begin
				res = {cin, a[15:1]};
				c = a[0];
			end
			isaPkg::OP_SXT: res = {{8{a[7]}}, a[7:0]};
			default: res = 16'h0000;
		endcase
		return {v, res[15], (res == 16'h0000), c, res};
	endfunction

	task automatic clearStrobes();
		pcWr_i <= 1'b0;
		regWr_i <= 1'b0;
		memEn_i <= 1'b0;
		irWr_i <= 1'b0;
		statWr_i <= 1'b0;
		flagsWr_i <= 1'b0;
		byteOp_i <= 1'b0;
	endtask

	task automatic nextEdge();
		@(posedge clk_i);
		clearStrobes();
	endtask

	// Let the DUT take the driven values, then sample in mid-cycle
	task automatic capture();
		nextEdge();
		@(negedge clk_i);
	endtask

	task automatic check(input string label, input logic [15:0] expVal,
		input logic [15:0] actVal);
		assert (actVal === expVal)
		else begin
			$display("mismatch %s %s: expected %h actual %h", testName, label, expVal, actVal);
			errCount++;
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testStartErrs = errCount;
	endtask

	task automatic endTest();
		if (errCount == testStartErrs) begin
			$display("test %s: ok", testName);
			passCount++;
		end else begin
			$display("test %s: %0d errors", testName, errCount - testStartErrs);
			failCount++;
		end
	endtask

	task automatic writeImm(input logic [2:0] r, input dpCtlPkg::regWrModeT m,
		input logic [15:0] v);
		nextEdge();
		regWr_i <= 1'b1;
		regWrSel_i <= dpCtlPkg::WR_IMM;
		regWrMode_i <= m;
		regWrAdr_i <= r;
		immVal_i <= v;
		refReg[r] = modeRef(refReg[r], v, m);
	endtask

	// Register contents come out through the OMDR
	task automatic readReg(input logic [2:0] r);
		nextEdge();
		memEn_i <= 1'b1;
		adrSel_i <= dpCtlPkg::ADR_PC;
		regAdrB_i <= r;
		capture();
		check($sformatf("r%0d", r), refReg[r], omdr_o);
	endtask

	task automatic checkMar(input string label, input logic [15:0] addr);
		memEn_i <= 1'b1;
		capture();
		check(label, {1'b0, addr[15:1]}, {1'b0, mar_o});
	endtask

	task automatic statusWrite(input dpCtlPkg::statWrModeT m, input logic [15:0] v,
		input logic withFlags);
		writeImm(3'd4, dpCtlPkg::WM_WORD, v);
		readReg(3'd4);
		nextEdge();
		statWr_i <= 1'b1;
		statWrMode_i <= m;
		flagsWr_i <= withFlags;
		flagsEn_i <= 4'hF;
		aluOp_i <= isaPkg::OP_MOV;
		aluBSel_i <= dpCtlPkg::BSEL_CONST;
		regAdrB_i <= 3'd0;
		case (m)
			dpCtlPkg::ST_LOAD: refStatus = v;
			dpCtlPkg::ST_SETBITS: refStatus = refStatus | v;
			dpCtlPkg::ST_CLRBITS: refStatus = refStatus & ~v;
			default: ;
		endcase
		capture();
		check("status word", refStatus, status_o);
	endtask

	initial begin
		rst_i = 1'b1;
		{pcWr_i, regWr_i, memEn_i, irWr_i, statWr_i, flagsWr_i, byteOp_i, pcSel_i} = '0;
		aluBSel_i = dpCtlPkg::BSEL_REGB;
		adrSel_i = dpCtlPkg::ADR_PC;
		statWrMode_i = dpCtlPkg::ST_KEEP;
		regWrMode_i = dpCtlPkg::WM_WORD;
		regWrSel_i = dpCtlPkg::WR_ALU;
		{regWrAdr_i, regAdrA_i, regAdrB_i, flagsEn_i} = '0;
		aluOp_i = isaPkg::OP_ADD;
		{mem_i, branchOffs_i, immVal_i, memOffs_i} = '0;
		for (int r = 0; r < 8; r++) begin
			refReg[r] = 16'h0000;
		end
		{refPc, refStatus, refIr} = '0;
		repeat (5) @(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);

		startTest("reset");
		check("mar", 16'h0000, {1'b0, mar_o});
		check("omdr", 16'h0000, omdr_o);
		check("ir", 16'h0000, ir_o);
		check("status", 16'h0000, status_o);
		check("badMem", 16'h0000, {15'd0, badMem_o});
		endTest();

		startTest("regModes");
		for (int r = 0; r < 8; r++) begin
			writeImm(r[2:0], dpCtlPkg::WM_WORD, randWord());
			writeImm(r[2:0], dpCtlPkg::regWrModeT'(r % 4), randWord());
		end
		for (int r = 0; r < 8; r++) begin
			readReg(r[2:0]);
		end
		endTest();

		// Operations rotate over the random pairs
		startTest("alu");
		for (int i = 0; i < 40; i++) begin
			op = isaPkg::aluOpT'(i % 13);
			opA = randWord();
			opB = randWord();
			writeImm(3'd1, dpCtlPkg::WM_WORD, opA);
			writeImm(3'd2, dpCtlPkg::WM_WORD, opB);
			nextEdge();
			aluOp_i <= op;
			regAdrA_i <= 3'd1;
			regAdrB_i <= 3'd2;
			aluBSel_i <= dpCtlPkg::BSEL_REGB;
			regWrSel_i <= dpCtlPkg::WR_ALU;
			regWrMode_i <= dpCtlPkg::WM_WORD;
			regWrAdr_i <= 3'd3;
			regWr_i <= 1'b1;
			flagsWr_i <= 1'b1;
			flagsEn_i <= 4'hF;
			aluOut = aluRef(op, opA, opB, refStatus[isaPkg::flagC]);
			refReg[3] = aluOut[15:0];
			refStatus[3:0] = aluOut[19:16];
			readReg(3'd3);
			check("flags", refStatus, status_o);
		end
		endTest();

		startTest("status");
		statusWrite(dpCtlPkg::ST_LOAD, 16'hA5C3, 1'b0);
		statusWrite(dpCtlPkg::ST_SETBITS, 16'h0F00, 1'b0);
		statusWrite(dpCtlPkg::ST_CLRBITS, 16'h00C3, 1'b0);
		for (int i = 0; i < 8; i++) begin
			opA = randWord();
			en = opA[3:0];
			nextEdge();
			aluOp_i <= isaPkg::OP_ADD;
			regAdrA_i <= 3'd1;
			aluBSel_i <= dpCtlPkg::BSEL_CONST;
			regAdrB_i <= i[2:0];
			flagsWr_i <= 1'b1;
			flagsEn_i <= en;
			aluOut = aluRef(isaPkg::OP_ADD, refReg[1], constRef[i], refStatus[isaPkg::flagC]);
			refStatus[3:0] = (refStatus[3:0] & ~en) | (aluOut[19:16] & en);
			capture();
			check("masked flags", refStatus, status_o);
		end
		// Word write and flag update in the same cycle
		statusWrite(dpCtlPkg::ST_LOAD, 16'h5A0C, 1'b1);
		endTest();

		startTest("address");
		for (int i = 0; i < 8; i++) begin
			opB = randWord();
			nextEdge();
			pcWr_i <= 1'b1;
			pcSel_i <= i[0];
			branchOffs_i <= opB;
			refPc = i[0] ? refPc + opB : refPc + 16'd2;
			nextEdge();
			adrSel_i <= dpCtlPkg::ADR_PC;
			checkMar("pc mar", refPc);
		end
		for (int k = 0; k < 8; k++) begin
			opA = randWord();
			opB = randWord();
			writeImm(3'd5, dpCtlPkg::WM_WORD, opA);
			nextEdge();
			adrSel_i <= dpCtlPkg::ADR_BASE;
			regAdrA_i <= 3'd5;
			checkMar("base mar", opA);
			nextEdge();
			adrSel_i <= dpCtlPkg::ADR_OFFSET;
			aluOp_i <= isaPkg::OP_ADD;
			aluBSel_i <= dpCtlPkg::BSEL_MEMOFFS;
			memOffs_i <= opB;
			checkMar("offset mar", opA + opB);
			nextEdge();
			aluBSel_i <= dpCtlPkg::BSEL_CONST;
			regAdrB_i <= k[2:0];
			checkMar("const mar", opA + constRef[k]);
		end
		for (int v = 0; v < 4; v++) begin
			writeImm(3'd6, dpCtlPkg::WM_WORD, alignVals[v]);
			for (int b = 0; b < 2; b++) begin
				nextEdge();
				adrSel_i <= dpCtlPkg::ADR_BASE;
				regAdrA_i <= 3'd6;
				regAdrB_i <= 3'd6;
				byteOp_i <= b[0];
				memEn_i <= 1'b1;
				@(negedge clk_i);
				odd = alignVals[v][0];
				check("badMem", {15'd0, (!b[0] && odd)}, {15'd0, badMem_o});
				check("datSel", {14'd0, b[0] ? (odd ? 2'd2 : 2'd1) : 2'd0}, {14'd0, datSel_o});
				check("pswAddr", {15'd0, (alignVals[v][15:1] == pswRef[15:1])},
					{15'd0, pswAddr_o});
			end
		end
		endTest();

		startTest("ir");
		for (int i = 0; i < 6; i++) begin
			opA = randWord();
			nextEdge();
			mem_i <= opA;
			irWr_i <= i[0];
			if (i[0]) begin
				refIr = opA;
			end
			capture();
			check("ir", refIr, ir_o);
		end
		endTest();

		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/datapath_props.sv
// Concurrent assertions on datapath register timing and alignment rules, with their bind
`timescale 1ns/1ns
`default_nettype none

module datapathProps (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic memEn_i,
	input wire logic irWr_i,
	input wire logic byteOp_i,
	input wire logic [isaPkg::wordW-1:0] mem_i,
	input wire logic badMem_o,
	input wire logic pswAddr_o,
	input wire logic [1:0] datSel_o,
	input wire logic [isaPkg::marW-1:0] mar_o,
	input wire logic [isaPkg::wordW-1:0] omdr_o,
	input wire logic [isaPkg::wordW-1:0] ir_o,
	input wire logic [isaPkg::wordW-1:0] status_o
);

	irLoad: assert property (@(posedge clk_i) disable iff (rst_i)
		irWr_i |=> (ir_o == $past(mem_i)))
		else $error("ir_o does not hold the memory word of the load edge");

	// Byte stores put the same byte on both lanes
	byteLanes: assert property (@(posedge clk_i) disable iff (rst_i)
		(memEn_i && byteOp_i) |=> (omdr_o[15:8] == omdr_o[7:0]))
		else $error("omdr_o bytes differ after a byte store");

	noBadByte: assert property (@(posedge clk_i) disable iff (rst_i)
		byteOp_i |-> !badMem_o)
		else $error("badMem_o high during a byte access");

	resetClears: assert property (@(posedge clk_i)
		rst_i |=> (mar_o == '0 && omdr_o == '0 && ir_o == '0 && status_o == '0 &&
			!badMem_o && !pswAddr_o && datSel_o == 2'd0))
		else $error("outputs not cleared after reset");

endmodule

bind datapath datapathProps u_props (
	.clk_i(clk_i), .rst_i(rst_i), .memEn_i(memEn_i), .irWr_i(irWr_i),
	.byteOp_i(byteOp_i), .mem_i(mem_i), .badMem_o(badMem_o), .pswAddr_o(pswAddr_o),
	.datSel_o(datSel_o), .mar_o(mar_o), .omdr_o(omdr_o), .ir_o(ir_o), .status_o(status_o)
);

`default_nettype wire
